// File: control_unit.f
+incdir+tb
rtl/ctrl_pkg.sv
rtl/instr_decode.sv
rtl/ctrl_sequencer.sv
rtl/ctrl_signal_gen.sv
rtl/control_unit.sv
tb/control_unit_tb.sv

// File: rtl/control_unit.sv
module control_unit (
        input  logic            clk,
        input  logic            reset,
        input  logic            overflow,
        input  logic            eq,
        input  logic            gt,
        input  ctrl_pkg::opcode_t op,
        input  ctrl_pkg::funct_t  funct,
        output ctrl_pkg::sel2_t pc_src,
        output ctrl_pkg::sel2_t alu_src_a,
        output ctrl_pkg::sel2_t alu_src_b,
        output ctrl_pkg::sel2_t sh_src,
        output ctrl_pkg::sel2_t sh_amt,
        output ctrl_pkg::sel2_t load_ctrl,
        output ctrl_pkg::sel2_t store_ctrl,
        output ctrl_pkg::sel3_t alu_op,
        output ctrl_pkg::sel3_t mem_addr_src,
        output ctrl_pkg::sel3_t sh_ctrl,
        output ctrl_pkg::sel3_t reg_dst,
        output ctrl_pkg::sel3_t reg_data_src,
        output logic            wr,
        output logic            ir_write,
        output logic            pc_write,
        output logic            reg_write,
        output logic            epc_write,
        output logic            a_write,
        output logic            b_write,
        output logic            alu_out_write,
        output logic            mdr_write
);
        import ctrl_pkg::*;

        instr_class_t instr_class;
        sel3_t        alu_op_r;
        sel3_t        shift_kind;
        logic         shift_var;
        branch_cond_t branch_cond;
        sel2_t        mem_size;
        ctrl_state_t  next_state;
        step_t        next_step;
        exc_cause_t   exc_cause;

        instr_decode decode0 (.*);

        ctrl_sequencer seq0 (.*);

        ctrl_signal_gen gen0 (.*);

endmodule

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

        typedef logic [5:0] opcode_t;
        typedef logic [5:0] funct_t;
        typedef logic [1:0] sel2_t;
        typedef logic [2:0] sel3_t;
        typedef logic [2:0] step_t;
        typedef logic [2:0] exc_cause_t;   // Doubles as mem_addr_src vector select

        typedef enum logic [3:0] {
                FETCH, DECODE, ALU_R, SET_LT, SHIFT, BRANCH,
                MEM_ADDR, LOAD, STORE, JUMP, JUMP_REG, EXCEPTION
        } ctrl_state_t;

        typedef enum logic [3:0] {
                C_ALU_R, C_SET_LT, C_SHIFT, C_BRANCH, C_LOAD,
                C_STORE, C_JUMP, C_JUMP_REG, C_ILLEGAL
        } instr_class_t;

        typedef enum logic [1:0] {BR_EQ, BR_NE, BR_GT, BR_LE} branch_cond_t;

        // Opcodes
        localparam opcode_t OP_R_TYPE = 6'h00;
        localparam opcode_t OP_J      = 6'h02;
        localparam opcode_t OP_BEQ    = 6'h04;
        localparam opcode_t OP_BNE    = 6'h05;
        localparam opcode_t OP_BLE    = 6'h06;
        localparam opcode_t OP_BGT    = 6'h07;
        localparam opcode_t OP_LB     = 6'h20;
        localparam opcode_t OP_LH     = 6'h21;
        localparam opcode_t OP_LW     = 6'h23;
        localparam opcode_t OP_SB     = 6'h28;
        localparam opcode_t OP_SH     = 6'h29;
        localparam opcode_t OP_SW     = 6'h2b;

        // R-type funct codes
        localparam funct_t FN_SLL  = 6'h00;
        localparam funct_t FN_SRL  = 6'h02;
        localparam funct_t FN_SRA  = 6'h03;
        localparam funct_t FN_SLLV = 6'h04;
        localparam funct_t FN_SRAV = 6'h07;
        localparam funct_t FN_JR   = 6'h08;
        localparam funct_t FN_ADD  = 6'h20;
        localparam funct_t FN_SUB  = 6'h22;
        localparam funct_t FN_AND  = 6'h24;
        localparam funct_t FN_SLT  = 6'h2a;

        localparam sel3_t ALU_LOAD_A = 3'd0;
        localparam sel3_t ALU_ADD    = 3'd1;
        localparam sel3_t ALU_SUB    = 3'd2;
        localparam sel3_t ALU_AND    = 3'd3;
        localparam sel3_t ALU_CMP    = 3'd7;

        localparam sel2_t A_SRC_PC     = 2'd0;
        localparam sel2_t A_SRC_B      = 2'd1;
        localparam sel2_t A_SRC_A      = 2'd2;
        localparam sel2_t B_SRC_B      = 2'd0;
        localparam sel2_t B_SRC_4      = 2'd1;
        localparam sel2_t B_SRC_OFFSET = 2'd2;
        localparam sel2_t B_SRC_BRANCH = 2'd3;

        localparam sel2_t PC_SRC_ALU     = 2'd0;
        localparam sel2_t PC_SRC_ALU_OUT = 2'd1;
        localparam sel2_t PC_SRC_JUMP    = 2'd2;
        localparam sel2_t PC_SRC_VECTOR  = 2'd3;

        localparam sel3_t ADDR_PC      = 3'd0;
        localparam sel3_t ADDR_ALU     = 3'd1;
        localparam sel3_t EXC_ILLEGAL  = 3'd2;   // Vector table entries
        localparam sel3_t EXC_OVERFLOW = 3'd3;

        localparam sel2_t SIZE_BYTE = 2'd1;
        localparam sel2_t SIZE_HALF = 2'd2;
        localparam sel2_t SIZE_WORD = 2'd3;

        localparam sel3_t SHIFT_NONE        = 3'd0;
        localparam sel3_t SHIFT_LOAD        = 3'd1;
        localparam sel3_t SHIFT_LEFT        = 3'd2;
        localparam sel3_t SHIFT_RIGHT_LOG   = 3'd3;
        localparam sel3_t SHIFT_RIGHT_ARITH = 3'd4;
        localparam sel2_t SH_SRC_A          = 2'd0;
        localparam sel2_t SH_SRC_B          = 2'd1;
        localparam sel2_t SH_AMT_FIELD      = 2'd0;
        localparam sel2_t SH_AMT_REG        = 2'd1;

        localparam sel3_t DST_RT       = 3'd0;
        localparam sel3_t DST_RD       = 3'd1;
        localparam sel3_t DATA_ALU_OUT = 3'd0;
        localparam sel3_t DATA_MDR     = 3'd1;
        localparam sel3_t DATA_SHIFT   = 3'd2;
        localparam sel3_t DATA_LT      = 3'd7;

        // Cycles spent in each state
        localparam step_t FETCH_STEPS    = 3'd4;
        localparam step_t DECODE_STEPS   = 3'd2;
        localparam step_t MEM_ADDR_STEPS = 3'd4;
        localparam step_t EXC_STEPS      = 3'd4;
        localparam step_t EXEC_STEPS     = 3'd2;
        localparam step_t SHIFT_STEPS    = 3'd3;
        localparam step_t MEM_STEPS      = 3'd1;

endpackage

// File: rtl/ctrl_sequencer.sv
module ctrl_sequencer (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   overflow,
        input  ctrl_pkg::instr_class_t instr_class,
        output ctrl_pkg::ctrl_state_t  next_state,
        output ctrl_pkg::step_t        next_step,
        output ctrl_pkg::exc_cause_t   exc_cause
);
        import ctrl_pkg::*;

        ctrl_state_t state;
        step_t       step;
        exc_cause_t  cause_q;
        logic        running;   // Low until the first FETCH begins

        function automatic step_t state_len(input ctrl_state_t s);
                case (s)
                        FETCH:      return FETCH_STEPS;
                        DECODE:     return DECODE_STEPS;
                        MEM_ADDR:   return MEM_ADDR_STEPS;
                        EXCEPTION:  return EXC_STEPS;
                        SHIFT:      return SHIFT_STEPS;
                        LOAD,
                        STORE:      return MEM_STEPS;
                        default:    return EXEC_STEPS;
                endcase
        endfunction

        always_comb begin
                next_state = state;
                next_step  = step + 3'd1;
                exc_cause  = cause_q;
                if (!running) begin
                        next_state = FETCH;
                        next_step  = '0;
                end else if (state == ALU_R && step == '0 && overflow) begin
                        next_state = EXCEPTION;
                        next_step  = '0;
                        exc_cause  = EXC_OVERFLOW;
                end else if (step == state_len(state) - 3'd1) begin
                        next_step = '0;
                        case (state)
                                FETCH:    next_state = DECODE;
                                DECODE: begin
                                        case (instr_class)
                                                C_ALU_R:    next_state = ALU_R;
                                                C_SET_LT:   next_state = SET_LT;
                                                C_SHIFT:    next_state = SHIFT;
                                                C_BRANCH:   next_state = BRANCH;
                                                C_LOAD,
                                                C_STORE:    next_state = MEM_ADDR;
                                                C_JUMP:     next_state = JUMP;
                                                C_JUMP_REG: next_state = JUMP_REG;
                                                default: begin
                                                        next_state = EXCEPTION;
                                                        exc_cause  = EXC_ILLEGAL;
                                                end
                                        endcase
                                end
                                MEM_ADDR: next_state = (instr_class == C_STORE) ? STORE : LOAD;
                                default:  next_state = FETCH;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state   <= FETCH;
                        step    <= '0;
                        cause_q <= EXC_ILLEGAL;
                        running <= 1'b0;
                end else begin
                        state   <= next_state;
                        step    <= next_step;
                        cause_q <= exc_cause;
                        running <= 1'b1;
                end
        end

endmodule

// File: rtl/ctrl_signal_gen.sv
module ctrl_signal_gen (
        input  logic                   clk,
        input  logic                   reset,
        input  ctrl_pkg::ctrl_state_t  next_state,
        input  ctrl_pkg::step_t        next_step,
        input  ctrl_pkg::exc_cause_t   exc_cause,
        input  ctrl_pkg::sel3_t        alu_op_r,
        input  ctrl_pkg::sel3_t        shift_kind,
        input  logic                   shift_var,
        input  ctrl_pkg::branch_cond_t branch_cond,
        input  ctrl_pkg::sel2_t        mem_size,
        input  logic                   eq,
        input  logic                   gt,
        output ctrl_pkg::sel2_t        pc_src,
        output ctrl_pkg::sel2_t        alu_src_a,
        output ctrl_pkg::sel2_t        alu_src_b,
        output ctrl_pkg::sel2_t        sh_src,
        output ctrl_pkg::sel2_t        sh_amt,
        output ctrl_pkg::sel2_t        load_ctrl,
        output ctrl_pkg::sel2_t        store_ctrl,
        output ctrl_pkg::sel3_t        alu_op,
        output ctrl_pkg::sel3_t        mem_addr_src,
        output ctrl_pkg::sel3_t        sh_ctrl,
        output ctrl_pkg::sel3_t        reg_dst,
        output ctrl_pkg::sel3_t        reg_data_src,
        output logic                   wr,
        output logic                   ir_write,
        output logic                   pc_write,
        output logic                   reg_write,
        output logic                   epc_write,
        output logic                   a_write,
        output logic                   b_write,
        output logic                   alu_out_write,
        output logic                   mdr_write
);
        import ctrl_pkg::*;

        logic taken;

        always_comb begin
                case (branch_cond)
                        BR_EQ:   taken = eq;
                        BR_NE:   taken = !eq;
                        BR_GT:   taken = gt;
                        default: taken = !gt;   // BLE
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        {pc_src, alu_src_a, alu_src_b, sh_src} <= '0;
                        {sh_amt, load_ctrl, store_ctrl} <= '0;
                        {alu_op, mem_addr_src, sh_ctrl, reg_dst, reg_data_src} <= '0;
                        {wr, ir_write, pc_write, reg_write, epc_write} <= '0;
                        {a_write, b_write, alu_out_write, mdr_write} <= '0;
                end else begin
                        // Selects hold, strobes last one cycle
                        {wr, ir_write, pc_write, reg_write, epc_write} <= '0;
                        {a_write, b_write, alu_out_write, mdr_write} <= '0;
                        case (next_state)
                                FETCH: begin
                                        mem_addr_src <= ADDR_PC;
                                        pc_src       <= PC_SRC_ALU_OUT;
                                        if (next_step < FETCH_STEPS - 3'd1) begin
                                                alu_src_a     <= A_SRC_PC;   // PC + 4
                                                alu_src_b     <= B_SRC_4;
                                                alu_op        <= ALU_ADD;
                                                alu_out_write <= 1'b1;
                                        end else begin
                                                ir_write <= 1'b1;
                                                pc_write <= 1'b1;
                                        end
                                end
                                DECODE: if (next_step == '0) begin
                                        alu_src_a     <= A_SRC_PC;   // Branch target ahead of time
                                        alu_src_b     <= B_SRC_BRANCH;
                                        alu_op        <= ALU_ADD;
                                        a_write       <= 1'b1;
                                        b_write       <= 1'b1;
                                        alu_out_write <= 1'b1;
                                end
                                ALU_R, SET_LT: begin
                                        if (next_step == '0) begin
                                                alu_src_a     <= A_SRC_A;
                                                alu_src_b     <= B_SRC_B;
                                                alu_op        <= (next_state == SET_LT) ?
                                                                ALU_CMP : alu_op_r;
                                                alu_out_write <= (next_state == ALU_R);
                                        end else begin
                                                reg_write    <= 1'b1;
                                                reg_dst      <= DST_RD;
                                                reg_data_src <= (next_state == SET_LT) ?
                                                                DATA_LT : DATA_ALU_OUT;
                                        end
                                end
                                SHIFT: begin
                                        case (next_step)
                                                3'd0: begin
                                                        sh_src  <= shift_var ? SH_SRC_A : SH_SRC_B;
                                                        sh_amt  <= shift_var ?
                                                                SH_AMT_REG : SH_AMT_FIELD;
                                                        sh_ctrl <= SHIFT_LOAD;
                                                end
                                                3'd1:    sh_ctrl <= shift_kind;
                                                default: begin
                                                        sh_ctrl      <= SHIFT_NONE;
                                                        reg_write    <= 1'b1;
                                                        reg_dst      <= DST_RD;
                                                        reg_data_src <= DATA_SHIFT;
                                                end
                                        endcase
                                end
                                BRANCH: begin
                                        if (next_step == '0) begin
                                                alu_src_a <= A_SRC_A;
                                                alu_src_b <= B_SRC_B;
                                                alu_op    <= ALU_CMP;
                                        end else if (taken) begin
                                                pc_write <= 1'b1;
                                                pc_src   <= PC_SRC_ALU_OUT;
                                        end
                                end
                                MEM_ADDR: begin
                                        if (next_step == '0) begin
                                                alu_src_a     <= A_SRC_A;
                                                alu_src_b     <= B_SRC_OFFSET;
                                                alu_op        <= ALU_ADD;
                                                alu_out_write <= 1'b1;
                                        end else if (next_step < MEM_ADDR_STEPS - 3'd1) begin
                                                mem_addr_src <= ADDR_ALU;
                                        end else begin
                                                mdr_write <= 1'b1;
                                        end
                                end
                                LOAD: begin
                                        reg_write    <= 1'b1;
                                        reg_dst      <= DST_RT;
                                        reg_data_src <= DATA_MDR;
                                        load_ctrl    <= mem_size;
                                end
                                STORE: begin
                                        wr         <= 1'b1;
                                        store_ctrl <= mem_size;
                                end
                                JUMP: if (next_step != '0) begin
                                        pc_write <= 1'b1;
                                        pc_src   <= PC_SRC_JUMP;
                                end
                                JUMP_REG: begin
                                        if (next_step == '0) begin
                                                alu_src_a     <= A_SRC_A;   // Pass rs through
                                                alu_op        <= ALU_LOAD_A;
                                                alu_out_write <= 1'b1;
                                        end else begin
                                                pc_write <= 1'b1;
                                                pc_src   <= PC_SRC_ALU;
                                        end
                                end
                                default: begin
                                        // Save PC - 4, read the handler address byte
                                        if (next_step < EXC_STEPS - 3'd1) begin
                                                alu_src_a    <= A_SRC_PC;
                                                alu_src_b    <= B_SRC_4;
                                                alu_op       <= ALU_SUB;
                                                epc_write    <= 1'b1;
                                                mdr_write    <= 1'b1;
                                                mem_addr_src <= exc_cause;
                                        end else begin
                                                load_ctrl <= SIZE_BYTE;
                                                pc_write  <= 1'b1;
                                                pc_src    <= PC_SRC_VECTOR;
                                        end
                                end
                        endcase
                end
        end

endmodule

// File: rtl/instr_decode.sv
module instr_decode (
        input  ctrl_pkg::opcode_t      op,
        input  ctrl_pkg::funct_t       funct,
        output ctrl_pkg::instr_class_t instr_class,
        output ctrl_pkg::sel3_t        alu_op_r,
        output ctrl_pkg::sel3_t        shift_kind,
        output logic                   shift_var,
        output ctrl_pkg::branch_cond_t branch_cond,
        output ctrl_pkg::sel2_t        mem_size
);
        import ctrl_pkg::*;

        always_comb begin
                instr_class = C_ILLEGAL;
                alu_op_r    = ALU_ADD;
                shift_kind  = SHIFT_LEFT;
                shift_var   = 1'b0;
                branch_cond = BR_EQ;
                mem_size    = SIZE_WORD;
                case (op)
                        OP_R_TYPE: begin
                                case (funct)
                                        FN_ADD:  instr_class = C_ALU_R;
                                        FN_SUB: begin
                                                instr_class = C_ALU_R;
                                                alu_op_r    = ALU_SUB;
                                        end
                                        FN_AND: begin
                                                instr_class = C_ALU_R;
                                                alu_op_r    = ALU_AND;
                                        end
                                        FN_SLT:  instr_class = C_SET_LT;
                                        FN_SLL:  instr_class = C_SHIFT;
                                        FN_SLLV: begin
                                                instr_class = C_SHIFT;
                                                shift_var   = 1'b1;   // Amount from rs
                                        end
                                        FN_SRL: begin
                                                instr_class = C_SHIFT;
                                                shift_kind  = SHIFT_RIGHT_LOG;
                                        end
                                        FN_SRA: begin
                                                instr_class = C_SHIFT;
                                                shift_kind  = SHIFT_RIGHT_ARITH;
                                        end
                                        FN_SRAV: begin
                                                instr_class = C_SHIFT;
                                                shift_kind  = SHIFT_RIGHT_ARITH;
                                                shift_var   = 1'b1;
                                        end
                                        FN_JR:   instr_class = C_JUMP_REG;
                                        default: instr_class = C_ILLEGAL;
                                endcase
                        end
                        OP_BEQ:  instr_class = C_BRANCH;
                        OP_BNE: begin
                                instr_class = C_BRANCH;
                                branch_cond = BR_NE;
                        end
                        OP_BGT: begin
                                instr_class = C_BRANCH;
                                branch_cond = BR_GT;
                        end
                        OP_BLE: begin
                                instr_class = C_BRANCH;
                                branch_cond = BR_LE;
                        end
                        OP_LB, OP_LH, OP_LW: instr_class = C_LOAD;
                        OP_SB, OP_SH, OP_SW: instr_class = C_STORE;
                        OP_J:    instr_class = C_JUMP;
                        default: instr_class = C_ILLEGAL;
                endcase
                // Access size shared by loads and stores
                if (op == OP_LB || op == OP_SB)
                        mem_size = SIZE_BYTE;
                else if (op == OP_LH || op == OP_SH)
                        mem_size = SIZE_HALF;
        end

endmodule

// File: tb/control_unit_tests.svh
// Strobe masks in the bit order of strobes()
localparam logic [8:0] S_NONE    = 9'h000;
localparam logic [8:0] S_MDR     = 9'h001;
localparam logic [8:0] S_ALU_OUT = 9'h002;
localparam logic [8:0] S_B       = 9'h004;
localparam logic [8:0] S_A       = 9'h008;
localparam logic [8:0] S_EPC     = 9'h010;
localparam logic [8:0] S_REG     = 9'h020;
localparam logic [8:0] S_PC      = 9'h040;
localparam logic [8:0] S_IR      = 9'h080;
localparam logic [8:0] S_WR      = 9'h100;

function automatic logic [8:0] strobes();
        return {wr, ir_write, pc_write, reg_write, epc_write,
                a_write, b_write, alu_out_write, mdr_write};
endfunction

// Outputs are registered, so the falling edge sees them settled
task automatic next_cycle(input logic [8:0] expected);
        @(negedge clk);
        check_eq("strobes", strobes(), expected);
endtask

task automatic finish_fetch();
        repeat (3) begin
                next_cycle(S_ALU_OUT);
                check_eq("mem_addr_src", mem_addr_src, ADDR_PC);
                check_eq("alu_op", alu_op, ALU_ADD);
        end
        next_cycle(S_IR | S_PC);
        check_eq("pc_src", pc_src, PC_SRC_ALU_OUT);
endtask

// Waits for the IR load, presents the instruction and walks through DECODE
task automatic issue(input opcode_t new_op, input funct_t new_funct, input logic ovf);
        int waited;
        waited = 0;
        while (ir_write !== 1'b1) begin
                @(negedge clk);
                waited++;
                if (waited > 16)
                        stop_run($sformatf("ir_write never pulsed before opcode 0x%h", new_op));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        op       = new_op;
        funct    = new_funct;
        overflow = ovf;
        eq       = lfsr_bit();   // Noise unless a branch reads it
        gt       = lfsr_bit();
        next_cycle(S_A | S_B | S_ALU_OUT);
        check_eq("alu_src_b", alu_src_b, B_SRC_BRANCH);
        next_cycle(S_NONE);
endtask

task automatic alu_case(input funct_t fn, input sel3_t code);
        issue(OP_R_TYPE, fn, 1'b0);
        next_cycle(S_ALU_OUT);
        check_eq("alu_op", alu_op, code);
        check_eq("alu_src_a", alu_src_a, A_SRC_A);
        check_eq("alu_src_b", alu_src_b, B_SRC_B);
        next_cycle(S_REG);
        check_eq("reg_dst", reg_dst, DST_RD);
        check_eq("reg_data_src", reg_data_src, DATA_ALU_OUT);
        finish_fetch();
endtask

task automatic run_alu_tests();
        alu_case(FN_ADD, ALU_ADD);
        alu_case(FN_SUB, ALU_SUB);
        alu_case(FN_AND, ALU_AND);
        issue(OP_R_TYPE, FN_SLT, 1'b0);
        next_cycle(S_NONE);   // Compare only
        check_eq("alu_op", alu_op, ALU_CMP);
        next_cycle(S_REG);
        check_eq("reg_dst", reg_dst, DST_RD);
        check_eq("reg_data_src", reg_data_src, DATA_LT);
        finish_fetch();
endtask

task automatic exception_seq(input sel3_t cause);
        repeat (3) begin
                next_cycle(S_EPC | S_MDR);
                check_eq("mem_addr_src", mem_addr_src, cause);
                check_eq("alu_op", alu_op, ALU_SUB);
        end
        next_cycle(S_PC);
        check_eq("pc_src", pc_src, PC_SRC_VECTOR);
        finish_fetch();
endtask

task automatic run_exception_tests();
        issue(OP_R_TYPE, FN_ADD, 1'b1);
        next_cycle(S_ALU_OUT);
        exception_seq(EXC_OVERFLOW);
        issue(6'h3f, lfsr_field(), lfsr_bit());
        exception_seq(EXC_ILLEGAL);
        issue(6'h0f, lfsr_field(), lfsr_bit());   // LUI no longer decoded
        exception_seq(EXC_ILLEGAL);
        issue(OP_R_TYPE, 6'h18, lfsr_bit());      // MULT funct
        exception_seq(EXC_ILLEGAL);
endtask

task automatic branch_case(input opcode_t bop);
        logic taken;
        issue(bop, lfsr_field(), lfsr_bit());
        case (bop)
                OP_BEQ:  taken = eq;
                OP_BNE:  taken = !eq;
                OP_BGT:  taken = gt;
                default: taken = !gt;
        endcase
        next_cycle(S_NONE);
        check_eq("alu_op", alu_op, ALU_CMP);
        next_cycle(taken ? S_PC : S_NONE);
        if (taken)
                check_eq("pc_src", pc_src, PC_SRC_ALU_OUT);
        finish_fetch();
endtask

task automatic run_branch_tests();
        repeat (BRANCH_TRIALS) begin
                branch_case(OP_BEQ);
                branch_case(OP_BNE);
                branch_case(OP_BGT);
                branch_case(OP_BLE);
        end
endtask

task automatic mem_case(input opcode_t mop, input logic store, input sel2_t size);
        issue(mop, lfsr_field(), lfsr_bit());
        next_cycle(S_ALU_OUT);
        check_eq("alu_src_b", alu_src_b, B_SRC_OFFSET);
        repeat (2) begin
                next_cycle(S_NONE);
                check_eq("mem_addr_src", mem_addr_src, ADDR_ALU);
        end
        next_cycle(S_MDR);
        if (store) begin
                next_cycle(S_WR);
                check_eq("store_ctrl", store_ctrl, size);
        end else begin
                next_cycle(S_REG);
                check_eq("reg_dst", reg_dst, DST_RT);
                check_eq("reg_data_src", reg_data_src, DATA_MDR);
                check_eq("load_ctrl", load_ctrl, size);
        end
        finish_fetch();
endtask

task automatic run_memory_tests();
        mem_case(OP_LB, 1'b0, SIZE_BYTE);
        mem_case(OP_LH, 1'b0, SIZE_HALF);
        mem_case(OP_LW, 1'b0, SIZE_WORD);
        mem_case(OP_SB, 1'b1, SIZE_BYTE);
        mem_case(OP_SH, 1'b1, SIZE_HALF);
        mem_case(OP_SW, 1'b1, SIZE_WORD);
endtask

task automatic shift_case(input funct_t fn, input sel3_t kind, input sel2_t src,
                input sel2_t amt);
        issue(OP_R_TYPE, fn, lfsr_bit());
        next_cycle(S_NONE);
        check_eq("sh_ctrl", sh_ctrl, SHIFT_LOAD);
        check_eq("sh_src", sh_src, src);
        check_eq("sh_amt", sh_amt, amt);
        next_cycle(S_NONE);
        check_eq("sh_ctrl", sh_ctrl, kind);
        next_cycle(S_REG);
        check_eq("reg_dst", reg_dst, DST_RD);
        check_eq("reg_data_src", reg_data_src, DATA_SHIFT);
        finish_fetch();
endtask

task automatic run_shift_tests();
        shift_case(FN_SLL, SHIFT_LEFT, SH_SRC_B, SH_AMT_FIELD);
        shift_case(FN_SRL, SHIFT_RIGHT_LOG, SH_SRC_B, SH_AMT_FIELD);
        shift_case(FN_SRA, SHIFT_RIGHT_ARITH, SH_SRC_B, SH_AMT_FIELD);
        shift_case(FN_SLLV, SHIFT_LEFT, SH_SRC_A, SH_AMT_REG);
        shift_case(FN_SRAV, SHIFT_RIGHT_ARITH, SH_SRC_A, SH_AMT_REG);
endtask

task automatic run_jump_tests();
        issue(OP_J, lfsr_field(), lfsr_bit());
        next_cycle(S_NONE);
        next_cycle(S_PC);
        check_eq("pc_src", pc_src, PC_SRC_JUMP);
        finish_fetch();
        issue(OP_R_TYPE, FN_JR, lfsr_bit());
        next_cycle(S_ALU_OUT);   // rs passed through the ALU
        check_eq("alu_op", alu_op, ALU_LOAD_A);
        next_cycle(S_PC);
        check_eq("pc_src", pc_src, PC_SRC_ALU);
        finish_fetch();
endtask

// File: tb/control_unit_tb.sv
module control_unit_tb;
        import ctrl_pkg::*;

        localparam int CLK_PERIOD    = 20;
        localparam int RESET_CYCLES  = 8;
        localparam int DRIVE_DELAY   = 2;
        localparam int BRANCH_TRIALS = 4;
        // Reset and first fetch, then 6 + execute cycles for every instruction issued
        localparam int RUN_CYCLES = RESET_CYCLES + 5 + 4 * 8 + 11 + 3 * 10
                + 4 * BRANCH_TRIALS * 8 + 6 * 11 + 5 * 9 + 2 * 8;

        logic    clk, reset, overflow, eq, gt;
        opcode_t op;
        funct_t  funct;
        sel2_t   pc_src, alu_src_a, alu_src_b, sh_src, sh_amt, load_ctrl, store_ctrl;
        sel3_t   alu_op, mem_addr_src, sh_ctrl, reg_dst, reg_data_src;
        logic    wr, ir_write, pc_write, reg_write, epc_write;
        logic    a_write, b_write, alu_out_write, mdr_write;

        logic [31:0] lfsr_q = 32'hb9bd_4ba3;

        control_unit dut0 (.*);

        always #(CLK_PERIOD / 2) clk = ~clk;

        // x^32 + x^22 + x^2 + x + 1
        function automatic logic lfsr_bit();
                logic fb;
                fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
                lfsr_q = {lfsr_q[30:0], fb};
                return fb;
        endfunction

        function automatic logic [5:0] lfsr_field();
                logic [5:0] v;
                int         i;
                for (i = 0; i < 6; i++)
                        v[i] = lfsr_bit();
                return v;
        endfunction

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("** FAIL **");
                $fatal(1, "Simulation stopped");
        endtask

        task automatic check_eq(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
                if (actual !== expected)
                        stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h at %0t",
                                name, actual, expected, $time));
        endtask

        `include "control_unit_tests.svh"

        initial begin
                #(CLK_PERIOD * (RUN_CYCLES + RUN_CYCLES / 4));
                stop_run("Timeout, the test sequence did not finish in the expected time");
        end

        initial begin
                clk      = 1'b0;
                reset    = 1'b1;
                overflow = 1'b0;
                eq       = 1'b0;
                gt       = 1'b0;
                op       = OP_R_TYPE;
                funct    = FN_ADD;
                repeat (RESET_CYCLES) @(posedge clk);
                #DRIVE_DELAY;
                reset = 1'b0;
                @(negedge clk);
                check_eq("strobes after reset", strobes(), '0);
                finish_fetch();   // First ir_write four cycles after release
                run_alu_tests();
                run_exception_tests();
                run_branch_tests();
                run_memory_tests();
                run_shift_tests();
                run_jump_tests();
                $display("** PASS **");
                $finish;
        end

endmodule
